//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb.f
verilog/rv_pkg.sv
verilog/rf_debug_if.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_exec_pipe.sv
verilog/rv_apb_regs.sv
verilog/rv_core_top.sv
tests/rv_core_properties.sv
tests/tb_top.sv

//--- tests/rv_core_properties.sv
// ------------------------------
// Protocol checks bound into the core top
// ------------------------------

`timescale 1ns/10ps

module rv_core_properties (
  input logic        clk,
  input logic        reset,
  input logic        run,
  input logic        busy,
  input logic        retire_valid,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [31:0] prdata,
  input logic        pready,
  input logic        pslverr
);

  // Two edges of latency, so three stopped edges means empty
  property drained_when_stopped;
    @(posedge clk) disable iff (reset)
      (!run && !$past(run) && !$past(run, 2)) |-> (!retire_valid && !busy);
  endproperty

  // Access phase follows a setup cycle
  property ready_in_access;
    @(posedge clk) disable iff (reset)
      pready |-> (psel && penable && $past(psel) && !$past(penable));
  endproperty

  // Error only while the window is locked, with zero read data
  property error_when_locked;
    @(posedge clk) disable iff (reset)
      pslverr |-> (pready && (run || busy) && (pwrite || prdata == '0));
  endproperty

  assert property (drained_when_stopped)
    else $error("Retire or busy seen after run stayed low for three cycles");
  assert property (ready_in_access)
    else $error("pready high outside an APB access phase");
  assert property (error_when_locked)
    else $error("pslverr high outside a locked window access or with read data");

endmodule

bind rv_core_top rv_core_properties props0 (
  .clk          (clk),
  .reset        (reset),
  .run          (run),
  .busy         (busy),
  .retire_valid (retire_valid),
  .psel         (psel),
  .penable      (penable),
  .pwrite       (pwrite),
  .prdata       (prdata),
  .pready       (pready),
  .pslverr      (pslverr)
);

//--- tests/tb_top.sv
// ------------------------------
// Testbench for the RV32I execute core
// Random ALU stream, APB window and retire model
// ------------------------------

`timescale 1ns/10ps

module tb_top;

  typedef struct packed {
    logic                          illegal;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::xlen-1:0]       data;
  } retire_exp_t;

  logic                          clk;
  logic                          reset;
  logic [31:0]                   inst;
  logic                          inst_valid;
  logic                          inst_ready;
  logic                          retire_valid;
  logic [rv_pkg::reg_addr_w-1:0] retire_rd;
  logic [rv_pkg::xlen-1:0]       retire_data;
  logic                          retire_illegal;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [rv_pkg::apb_addr_w-1:0] paddr;
  logic [31:0]                   pwdata;
  logic [31:0]                   prdata;
  logic                          pready;
  logic                          pslverr;

  logic [31:0]                   rng_state;
  logic [rv_pkg::xlen-1:0]       model_regs [rv_pkg::num_regs];
  retire_exp_t                   expected_q [$];
  retire_exp_t                   retire_exp;
  // Two most recent destinations, to force bypass hits
  logic [rv_pkg::reg_addr_w-1:0] last_rd [2];
  int                            accepted;
  int                            illegal_seen;
  int                            value_errors;
  int                            other_errors;

  rv_core_top dut0 (
    .clk            (clk),
    .reset          (reset),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_word(input string name, input logic [rv_pkg::xlen-1:0] expected,
                            input logic [rv_pkg::xlen-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_reg(input string name, input logic [rv_pkg::reg_addr_w-1:0] expected,
                           input logic [rv_pkg::reg_addr_w-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR %s: expected x%0d, actual x%0d", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic is_legal(input rv_pkg::rv_inst_t w);
    return w.r.opcode == rv_pkg::opc_op || w.r.opcode == rv_pkg::opc_op_imm ||
           w.r.opcode == rv_pkg::opc_lui;
  endfunction

  function automatic logic [31:0] model_result(input rv_pkg::rv_inst_t w,
                                               input logic [31:0] a, input logic [31:0] rs2_val);
    logic [31:0] b;
    logic [31:0] sra_val;
    logic [4:0]  sh;
    if (w.r.opcode == rv_pkg::opc_lui) begin
      return {w.u.imm, 12'h000};
    end
    b       = (w.r.opcode == rv_pkg::opc_op) ? rs2_val : {{20{w.i.imm[11]}}, w.i.imm};
    sh      = b[4:0];
    sra_val = $signed(a) >>> sh;
    case (w.r.funct3)
      3'd0:    return (w.r.opcode == rv_pkg::opc_op && w.r.funct7[5]) ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return w.r.funct7[5] ? sra_val : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic apply_model(input rv_pkg::rv_inst_t w);
    retire_exp_t e;
    e.illegal = !is_legal(w);
    e.rd      = w.r.rd;
    e.data    = model_result(w, model_regs[w.r.rs1], model_regs[w.r.rs2]);
    expected_q.push_back(e);
    if (!e.illegal && w.r.rd != 5'd0) begin
      model_regs[w.r.rd] = e.data;
    end
    accepted++;
    last_rd[1] = last_rd[0];
    last_rd[0] = w.r.rd;
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic make_inst(output rv_pkg::rv_inst_t w);
    logic [31:0] r;
    logic [31:0] s;
    r = next_rand();
    s = next_rand();
    w = s;
    w.r.funct3 = r[25:23];
    case (r[2:0])
      3'd0, 3'd1, 3'd2: begin
        w.r.opcode = rv_pkg::opc_op;
        w.r.funct7 = ((r[25:23] == 3'd0 || r[25:23] == 3'd5) && r[22]) ? 7'h20 : 7'h00;
      end
      3'd3, 3'd4, 3'd5: begin
        w.r.opcode = rv_pkg::opc_op_imm;
        // Shift immediates carry only the srai flag above shamt
        if (r[25:23] == 3'd1) w.r.funct7 = 7'h00;
        if (r[25:23] == 3'd5) w.r.funct7 = r[22] ? 7'h20 : 7'h00;
      end
      3'd6: w.r.opcode = rv_pkg::opc_lui;
      default: begin
        case (r[21:20])
          2'd0:    w.r.opcode = 7'b0000011;
          2'd1:    w.r.opcode = 7'b0100011;
          2'd2:    w.r.opcode = 7'b1100011;
          default: w.r.opcode = 7'b1101111;
        endcase
      end
    endcase
    w.r.rd  = r[7:3];
    w.r.rs1 = r[8] ? last_rd[0] : r[13:9];
    w.r.rs2 = r[14] ? last_rd[1] : r[19:15];
  endtask

  task automatic run_stream(input int count);
    rv_pkg::rv_inst_t w;
    logic [31:0]      r;
    int               sent;
    int               tries;
    sent  = 0;
    tries = 0;
    w     = '0;
    while (sent < count && tries < count * 4) begin
      r = next_rand();
      @(negedge clk);
      // Occasional bubble
      if (r[3:0] == 4'h0) begin
        inst_valid = 1'b0;
      end else begin
        make_inst(w);
        inst       = w;
        inst_valid = 1'b1;
      end
      @(posedge clk);
      if (inst_valid && inst_ready) begin
        apply_model(w);
        sent++;
      end
      tries++;
    end
    @(negedge clk);
    inst_valid = 1'b0;
    if (sent < count) begin
      other_errors++;
      $display("Instruction stream stalled, only %0d of %0d accepted", sent, count);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < 50) begin
      @(posedge clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      other_errors++;
      $display("Timed out waiting for %0d instructions to retire", expected_q.size());
    end
  endtask

  // Retire monitor, in order against the model queue
  always @(posedge clk) begin
    if (!reset && retire_valid) begin
      if (expected_q.size() == 0) begin
        other_errors++;
        $display("Retire of x%0d arrived with no instruction outstanding", retire_rd);
      end else begin
        retire_exp = expected_q.pop_front();
        check_reg("retire rd", retire_exp.rd, retire_rd);
        check_flag("retire illegal", retire_exp.illegal, retire_illegal);
        if (!retire_exp.illegal) begin
          check_word("retire data", retire_exp.data, retire_data);
        end
        if (retire_illegal) illegal_seen++;
      end
    end
  end

  // ------------------------------
  // APB driver
  // ------------------------------
  task automatic apb_access(input logic wr, input logic [rv_pkg::apb_addr_w-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    @(posedge clk);
    while (!pready && waited < 16) begin
      @(posedge clk);
      waited++;
    end
    if (!pready) begin
      other_errors++;
      $display("APB access to offset %h never saw pready", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [rv_pkg::apb_addr_w-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused_rdata;
    apb_access(1'b1, addr, data, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [rv_pkg::apb_addr_w-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  function automatic logic [rv_pkg::apb_addr_w-1:0] window_addr(input logic [4:0] n);
    return rv_pkg::rf_window_base + {5'b0, n, 2'b00};
  endfunction

  task automatic wait_idle();
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    apb_read(rv_pkg::reg_status, st, err);
    while (st[0] && polls < 20) begin
      apb_read(rv_pkg::reg_status, st, err);
      polls++;
    end
    if (st[0]) begin
      other_errors++;
      $display("Pipeline still busy after run was cleared");
    end
    check_word("status idle", 32'd0, st);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [31:0] rdata;
    logic [31:0] wval;
    logic        err;
    rng_state    = 32'hdf7b_8bf9;
    accepted     = 0;
    illegal_seen = 0;
    value_errors = 0;
    other_errors = 0;
    last_rd[0]   = 5'd0;
    last_rd[1]   = 5'd0;
    for (int n = 0; n < rv_pkg::num_regs; n++) model_regs[n] = '0;
    reset      = 1'b1;
    inst       = 32'd0;
    inst_valid = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = 32'd0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Reset state
    check_flag("reset inst_ready", 1'b0, inst_ready);
    check_flag("reset retire_valid", 1'b0, retire_valid);
    apb_read(rv_pkg::reg_ctrl, rdata, err);
    check_word("reset ctrl", 32'd0, rdata);
    apb_read(rv_pkg::reg_status, rdata, err);
    check_word("reset status", 32'd0, rdata);
    apb_read(rv_pkg::reg_retired, rdata, err);
    check_word("reset retired count", 32'd0, rdata);

    // Debug window, x0 included
    for (int n = 0; n < rv_pkg::num_regs; n++) begin
      wval = next_rand();
      apb_write(window_addr(5'(n)), wval, err);
      check_flag("window write error", 1'b0, err);
      if (n != 0) model_regs[n] = wval;
    end
    for (int n = 0; n < rv_pkg::num_regs; n++) begin
      apb_read(window_addr(5'(n)), rdata, err);
      check_word($sformatf("window readback x%0d", n), model_regs[n], rdata);
    end

    // Window is locked while running
    apb_write(rv_pkg::reg_ctrl, 32'd1, err);
    apb_write(window_addr(5'd5), ~model_regs[5], err);
    check_flag("window write while running", 1'b1, err);
    apb_read(window_addr(5'd5), rdata, err);
    check_flag("window read while running", 1'b1, err);
    check_word("window read data while running", 32'd0, rdata);
    apb_write(rv_pkg::reg_ctrl, 32'd0, err);
    apb_read(window_addr(5'd5), rdata, err);
    check_word("x5 after refused write", model_regs[5], rdata);

    // Random ALU stream with illegal words mixed in
    apb_write(rv_pkg::reg_retired, 32'd0, err);
    apb_write(rv_pkg::reg_ctrl, 32'd1, err);
    run_stream(300);
    wait_drain();
    apb_write(rv_pkg::reg_ctrl, 32'd0, err);
    wait_idle();

    for (int n = 0; n < rv_pkg::num_regs; n++) begin
      apb_read(window_addr(5'(n)), rdata, err);
      check_word($sformatf("final x%0d", n), model_regs[n], rdata);
    end
    check_flag("illegal retires seen", 1'b1, illegal_seen != 0);

    // Retire count and clear on write
    apb_read(rv_pkg::reg_retired, rdata, err);
    check_word("retired count", accepted, rdata);
    apb_write(rv_pkg::reg_retired, 32'hffff_ffff, err);
    apb_read(rv_pkg::reg_retired, rdata, err);
    check_word("retired count cleared", 32'd0, rdata);

    $display("Errors: %0d value mismatches, %0d timeouts or protocol faults",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/rf_debug_if.sv
// ------------------------------
// Debug access path into the register file
// ------------------------------

`timescale 1ns/10ps

interface rf_debug_if;

  // Write strobe, qualified by the APB block
  logic                          wen;
  logic [rv_pkg::reg_addr_w-1:0] addr;
  logic [rv_pkg::xlen-1:0]       wdata;
  // Combinational read of addr
  logic [rv_pkg::xlen-1:0]       rdata;

  modport apb (
    output wen, addr, wdata,
    input  rdata
  );

  modport rf (
    input  wen, addr, wdata,
    output rdata
  );

endinterface

//--- verilog/rv_alu.sv
// ------------------------------
// Integer ALU for the RV32I register ops
// ------------------------------

`timescale 1ns/10ps

module rv_alu (
  input  logic [rv_pkg::xlen-1:0]     in_a,
  input  logic [rv_pkg::xlen-1:0]     in_b,
  input  logic [rv_pkg::alu_op_w-1:0] fn,
  output logic [rv_pkg::xlen-1:0]     result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shifts use only the low five bits
  assign shamt = in_b[4:0];

  assign lt_signed   = $signed(in_a) < $signed(in_b);
  assign lt_unsigned = in_a < in_b;

  always_comb begin
    case (fn)
      rv_pkg::alu_add:    result = in_a + in_b;
      rv_pkg::alu_sub:    result = in_a - in_b;
      rv_pkg::alu_sll:    result = in_a << shamt;
      rv_pkg::alu_slt:    result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
      rv_pkg::alu_sltu:   result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
      rv_pkg::alu_xor:    result = in_a ^ in_b;
      rv_pkg::alu_srl:    result = in_a >> shamt;
      // Arithmetic shift keeps the sign bit
      rv_pkg::alu_sra:    result = $signed(in_a) >>> shamt;
      rv_pkg::alu_or:     result = in_a | in_b;
      rv_pkg::alu_and:    result = in_a & in_b;
      rv_pkg::alu_pass_b: result = in_b;
      default:            result = '0;
    endcase
  end

endmodule

//--- verilog/rv_apb_regs.sv
// ------------------------------
// APB control block for the execute core
// Run bit, status, retire count, register file window
// ------------------------------

`timescale 1ns/10ps

module rv_apb_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [rv_pkg::apb_addr_w-1:0] paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic                          busy,
  input  logic                          retire_valid,
  output logic                          run,
  rf_debug_if.apb                       dbg
);

  logic        access;
  logic        wr_en;
  logic        win_hit;
  logic        win_err;
  logic [31:0] retired_cnt;

  // ------------------------------
  // Access decode
  // ------------------------------
  // No wait states, every access phase completes
  assign access = psel & penable;
  assign wr_en  = access & pwrite;
  assign pready = access;

  // Window spans 4 bytes per register
  assign win_hit = paddr[rv_pkg::apb_addr_w-1:rv_pkg::reg_addr_w+2] ==
                   rv_pkg::rf_window_base[rv_pkg::apb_addr_w-1:rv_pkg::reg_addr_w+2];

  // Register file only reachable when stopped and drained
  assign win_err = win_hit & (run | busy);
  assign pslverr = access & win_err;

  assign dbg.addr  = paddr[rv_pkg::reg_addr_w+1:2];
  assign dbg.wdata = pwdata;
  assign dbg.wen   = wr_en & win_hit & ~win_err;

  // ------------------------------
  // Register updates
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      run         <= 1'b0;
      retired_cnt <= '0;
    end else begin
      if (wr_en && paddr == rv_pkg::reg_ctrl) begin
        run <= pwdata[0];
      end
      // Any write clears the count
      if (wr_en && paddr == rv_pkg::reg_retired) begin
        retired_cnt <= '0;
      end else if (retire_valid) begin
        retired_cnt <= retired_cnt + 32'd1;
      end
    end
  end

  // Read mux, unmapped offsets give zero
  always_comb begin
    prdata = '0;
    if (win_hit) begin
      if (!win_err) begin
        prdata = dbg.rdata;
      end
    end else begin
      case (paddr)
        rv_pkg::reg_ctrl:    prdata = {31'b0, run};
        rv_pkg::reg_status:  prdata = {31'b0, busy};
        rv_pkg::reg_retired: prdata = retired_cnt;
        default:             prdata = '0;
      endcase
    end
  end

endmodule

//--- verilog/rv_core_top.sv
// ------------------------------
// RV32I execute core top level
// Pipeline, register file and APB block
// ------------------------------

`timescale 1ns/10ps

module rv_core_top (
  input  logic                          clk,
  input  logic                          reset,
  // Instruction stream
  input  logic [31:0]                   inst,
  input  logic                          inst_valid,
  output logic                          inst_ready,
  // Retire stream
  output logic                          retire_valid,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data,
  output logic                          retire_illegal,
  // APB
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [rv_pkg::apb_addr_w-1:0] paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr
);

  logic                          run;
  logic                          busy;
  logic [rv_pkg::reg_addr_w-1:0] raddr0;
  logic [rv_pkg::reg_addr_w-1:0] raddr1;
  logic [rv_pkg::xlen-1:0]       rdata0;
  logic [rv_pkg::xlen-1:0]       rdata1;
  logic                          wb_wen;
  logic [rv_pkg::reg_addr_w-1:0] wb_addr;
  logic [rv_pkg::xlen-1:0]       wb_data;

  rf_debug_if dbg_bus ();

  rv_exec_pipe pipe0 (
    .clk            (clk),
    .reset          (reset),
    .run            (run),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .raddr0         (raddr0),
    .raddr1         (raddr1),
    .rdata0         (rdata0),
    .rdata1         (rdata1),
    .wb_wen         (wb_wen),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal),
    .busy           (busy)
  );

  rv_regfile rf0 (
    .clk     (clk),
    .raddr0  (raddr0),
    .raddr1  (raddr1),
    .rdata0  (rdata0),
    .rdata1  (rdata1),
    .wb_wen  (wb_wen),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .dbg     (dbg_bus.rf)
  );

  rv_apb_regs regs0 (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .busy         (busy),
    .retire_valid (retire_valid),
    .run          (run),
    .dbg          (dbg_bus.apb)
  );

endmodule

//--- verilog/rv_exec_pipe.sv
// ------------------------------
// In-order execute pipeline, decode -> X -> W
// Bypassing from X and W, retire from W
// ------------------------------

`timescale 1ns/10ps

module rv_exec_pipe (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          run,
  input  rv_pkg::rv_inst_t              inst,
  input  logic                          inst_valid,
  output logic                          inst_ready,
  output logic [rv_pkg::reg_addr_w-1:0] raddr0,
  output logic [rv_pkg::reg_addr_w-1:0] raddr1,
  input  logic [rv_pkg::xlen-1:0]       rdata0,
  input  logic [rv_pkg::xlen-1:0]       rdata1,
  output logic                          wb_wen,
  output logic [rv_pkg::reg_addr_w-1:0] wb_addr,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          retire_valid,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data,
  output logic                          retire_illegal,
  output logic                          busy
);

  logic                          accept;
  logic [rv_pkg::xlen-1:0]       imm_i;
  logic [rv_pkg::xlen-1:0]       imm_sh;
  logic [rv_pkg::xlen-1:0]       imm_u;
  logic [rv_pkg::xlen-1:0]       src_a;
  logic [rv_pkg::xlen-1:0]       src_b;
  logic [rv_pkg::xlen-1:0]       dec_b;
  logic [rv_pkg::alu_op_w-1:0]   dec_fn;
  logic                          dec_legal;
  logic [rv_pkg::xlen-1:0]       alu_out;
  // X stage
  logic                          x_valid;
  logic                          x_wen;
  logic                          x_illegal;
  logic [rv_pkg::reg_addr_w-1:0] x_rd;
  logic [rv_pkg::alu_op_w-1:0]   x_fn;
  logic [rv_pkg::xlen-1:0]       x_a;
  logic [rv_pkg::xlen-1:0]       x_b;
  // W stage
  logic                          w_valid;
  logic                          w_wen;
  logic                          w_illegal;
  logic [rv_pkg::reg_addr_w-1:0] w_rd;
  logic [rv_pkg::xlen-1:0]       w_data;

  // funct3 to ALU code, alt selects sub / sra
  function automatic logic [rv_pkg::alu_op_w-1:0] alu_code(input logic [2:0] funct3,
                                                           input logic       alt);
    case (funct3)
      3'b000:  alu_code = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  alu_code = rv_pkg::alu_sll;
      3'b010:  alu_code = rv_pkg::alu_slt;
      3'b011:  alu_code = rv_pkg::alu_sltu;
      3'b100:  alu_code = rv_pkg::alu_xor;
      3'b101:  alu_code = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  alu_code = rv_pkg::alu_or;
      default: alu_code = rv_pkg::alu_and;
    endcase
  endfunction

  assign inst_ready = run;
  assign accept     = inst_valid & run;
  assign busy       = x_valid | w_valid;

  // ------------------------------
  // Decode
  // ------------------------------
  assign raddr0 = inst.r.rs1;
  assign raddr1 = inst.r.rs2;

  assign imm_i  = {{(rv_pkg::xlen-12){inst.i.imm[11]}}, inst.i.imm};
  assign imm_sh = {{(rv_pkg::xlen-5){1'b0}}, inst.r.rs2};
  assign imm_u  = {inst.u.imm, 12'b0};

  always_comb begin
    dec_legal = 1'b1;
    dec_fn    = rv_pkg::alu_add;
    dec_b     = src_b;
    case (inst.r.opcode)
      rv_pkg::opc_op: begin
        dec_fn = alu_code(inst.r.funct3, inst.r.funct7[5]);
      end
      rv_pkg::opc_op_imm: begin
        // No subtract form here, bit 30 only picks srai
        dec_fn = alu_code(inst.i.funct3, inst.r.funct7[5] && inst.i.funct3 == 3'b101);
        dec_b  = (inst.i.funct3[1:0] == 2'b01) ? imm_sh : imm_i;
      end
      rv_pkg::opc_lui: begin
        dec_fn = rv_pkg::alu_pass_b;
        dec_b  = imm_u;
      end
      default: dec_legal = 1'b0;
    endcase
  end

  // Bypass, youngest producer first. x0 never matches a writer
  always_comb begin
    if (x_valid && x_wen && x_rd == inst.r.rs1) src_a = alu_out;
    else if (w_valid && w_wen && w_rd == inst.r.rs1) src_a = w_data;
    else src_a = rdata0;
  end

  always_comb begin
    if (x_valid && x_wen && x_rd == inst.r.rs2) src_b = alu_out;
    else if (w_valid && w_wen && w_rd == inst.r.rs2) src_b = w_data;
    else src_b = rdata1;
  end

  // ------------------------------
  // X and W stages
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      x_valid <= 1'b0;
      w_valid <= 1'b0;
    end else begin
      x_valid <= accept;
      w_valid <= x_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      x_a       <= src_a;
      x_b       <= dec_b;
      x_fn      <= dec_fn;
      x_rd      <= inst.r.rd;
      x_wen     <= dec_legal && inst.r.rd != '0;
      x_illegal <= ~dec_legal;
    end
    w_data    <= alu_out;
    w_rd      <= x_rd;
    w_wen     <= x_wen;
    w_illegal <= x_illegal;
  end

  rv_alu alu0 (
    .in_a   (x_a),
    .in_b   (x_b),
    .fn     (x_fn),
    .result (alu_out)
  );

  // Writeback and retire both come from W
  assign wb_wen         = w_valid & w_wen;
  assign wb_addr        = w_rd;
  assign wb_data        = w_data;
  assign retire_valid   = w_valid;
  assign retire_rd      = w_rd;
  assign retire_data    = w_data;
  assign retire_illegal = w_illegal;

endmodule

//--- verilog/rv_pkg.sv
// ------------------------------
// RV32I execute core package
// Widths, opcodes, ALU codes, APB map, instruction views
// ------------------------------

package rv_pkg;

  // Datapath sizes
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // Opcodes of the supported formats
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  // ------------------------------
  // ALU function codes
  // ------------------------------
  localparam int alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
  // Operand b straight through, for lui
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  // ------------------------------
  // APB register map
  // ------------------------------
  localparam int apb_addr_w = 12;

  localparam logic [apb_addr_w-1:0] reg_ctrl       = 12'h000;
  localparam logic [apb_addr_w-1:0] reg_status     = 12'h004;
  localparam logic [apb_addr_w-1:0] reg_retired    = 12'h008;
  // xN at base + 4*N
  localparam logic [apb_addr_w-1:0] rf_window_base = 12'h080;

  // Instruction word formats
  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } rv_inst_t;

endpackage

//--- verilog/rv_regfile.sv
// ------------------------------
// Integer register file, 32 x 32
// Two read ports, pipeline write port and debug port
// ------------------------------

`timescale 1ns/10ps

module rv_regfile (
  input  logic                          clk,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr0,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
  output logic [rv_pkg::xlen-1:0]       rdata0,
  output logic [rv_pkg::xlen-1:0]       rdata1,
  input  logic                          wb_wen,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_addr,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  rf_debug_if.rf                        dbg
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] mem [1:rv_pkg::num_regs-1];

  // ------------------------------
  // Write port
  // ------------------------------
  // Debug writes only happen with the pipeline empty,
  // so the two sources never collide
  always_ff @(posedge clk) begin
    if (wb_wen && wb_addr != '0) begin
      mem[wb_addr] <= wb_data;
    end else if (dbg.wen && dbg.addr != '0) begin
      mem[dbg.addr] <= dbg.wdata;
    end
  end

  // ------------------------------
  // Read ports
  // ------------------------------
  // x0 always reads zero
  assign rdata0 = (raddr0 == '0) ? '0 : mem[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];

  assign dbg.rdata = (dbg.addr == '0) ? '0 : mem[dbg.addr];

endmodule
